//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - verilog/icache_pkg.sv
      - verilog/icache_addr_decode.sv
      - verilog/icache_tag_array.sv
      - verilog/icache_refill_ctrl.sv
      - verilog/icache_data_array.sv
      - verilog/icache_top.sv
  - target: test
    files:
      - bench/icache_checker.sv
      - bench/tb_icache.sv

//--- all.f
verilog/icache_pkg.sv
verilog/icache_addr_decode.sv
verilog/icache_tag_array.sv
verilog/icache_refill_ctrl.sv
verilog/icache_data_array.sv
verilog/icache_top.sv
bench/icache_checker.sv
bench/tb_icache.sv

//--- bench/icache_checker.sv
`timescale 1ns/100ps
`default_nettype none

module icache_checker
    import icache_pkg::*;
#(
    parameter int BLOCK_WORDS = 4,
    localparam int BLOCK_LSB  = BYTE_OFFSET_BITS + $clog2(BLOCK_WORDS)
) (
    input logic                 Clk,
    input logic                 arst_n,
    input logic                 ready,
    input logic                 busy,
    input logic                 mispredict,
    input logic                 mem_read_request,
    input logic [ADDR_BITS-1:0] mem_read_address
);

    int          failures = 0;
    fill_state_t req_state;

    // Refill state as seen from the memory side
    assign req_state = mem_read_request ? FILL_COLLECT : FILL_IDLE;

    a_request_busy: assert property (@(posedge Clk) disable iff (!arst_n)
        mem_read_request |-> busy)
        else begin
            $error("mem_read_request high while busy is low");
            failures++;
        end

    a_ready_pulse: assert property (@(posedge Clk) disable iff (!arst_n)
        ready |=> !ready)
        else begin
            $error("ready high for two cycles");
            failures++;
        end

    a_block_aligned: assert property (@(posedge Clk) disable iff (!arst_n)
        mem_read_request |-> (mem_read_address[BLOCK_LSB-1:0] == '0))
        else begin
            $error("mem_read_address not block aligned");
            failures++;
        end

    // Aborted refill never delivers
    a_abort_silent: assert property (@(posedge Clk) disable iff (!arst_n)
        (req_state == FILL_COLLECT && mispredict) |=> !ready)
        else begin
            $error("ready pulse after an aborting mispredict");
            failures++;
        end

endmodule

bind icache_top icache_checker #(
    .BLOCK_WORDS (BLOCK_WORDS)
) i_checker (
    .Clk              (Clk),
    .arst_n           (arst_n),
    .ready            (ready),
    .busy             (busy),
    .mispredict       (mispredict),
    .mem_read_request (mem_read_request),
    .mem_read_address (mem_read_address)
);

`default_nettype wire

//--- bench/tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_icache;

    localparam int SETS       = 4;
    localparam int WAYS       = 2;
    localparam int WORDS      = 4;
    localparam int SET_LSB    = 2 + $clog2(WORDS);
    localparam int TAG_LSB    = SET_LSB + $clog2(SETS);
    localparam int NONE       = 15;
    localparam int N_ENTRIES  = 16;
    localparam int WAIT_LIMIT = WORDS * 4 + 10;
    localparam int TIMEOUT_NS = N_ENTRIES * WAIT_LIMIT * 20;

    typedef enum logic [1:0] {
        OUT_HIT,
        OUT_MISS,
        OUT_ABORT
    } outcome_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  abort_after;
        outcome_t    outcome;
        logic        hold;
    } entry_t;

    // Fetch address, words delivered before mispredict, outcome, hold read_enable
    localparam entry_t STIM [N_ENTRIES] = '{
        '{32'h0000_1008, 4'(NONE), OUT_MISS,  1'b0},
        '{32'h0000_1008, 4'(NONE), OUT_HIT,   1'b0},
        '{32'h0000_1000, 4'(NONE), OUT_HIT,   1'b0},
        '{32'h0000_1004, 4'(NONE), OUT_HIT,   1'b0},
        '{32'h0000_100C, 4'(NONE), OUT_HIT,   1'b0},
        '{32'h0000_2004, 4'(NONE), OUT_MISS,  1'b0},
        '{32'h0000_3000, 4'(NONE), OUT_MISS,  1'b0},
        '{32'h0000_2008, 4'(NONE), OUT_HIT,   1'b0},
        '{32'h0000_1000, 4'(NONE), OUT_MISS,  1'b0},
        '{32'h0000_3004, 4'(NONE), OUT_HIT,   1'b0},
        '{32'h0000_4010, 4'd3,     OUT_ABORT, 1'b0},
        '{32'h0000_4010, 4'd0,     OUT_ABORT, 1'b0},
        '{32'h0000_4010, 4'(NONE), OUT_MISS,  1'b1},
        '{32'h0000_4014, 4'(NONE), OUT_HIT,   1'b0},
        '{32'h0000_5028, 4'(NONE), OUT_MISS,  1'b1},
        '{32'h0000_502C, 4'(NONE), OUT_HIT,   1'b0}
    };

    logic        Clk = 1'b0;
    logic        arst_n;
    logic        read_enable;
    logic [31:0] read_address;
    logic        mispredict;
    logic [31:0] mem_data;
    logic        mem_data_ready;
    logic [31:0] instruction;
    logic        ready;
    logic        busy;
    logic [31:0] mem_read_address;
    logic        mem_read_request;

    logic [31:0] lfsr;
    int          errors;
    int          checks;

    // Reference model of the tag store
    logic [31:0] m_tag   [SETS][WAYS];
    logic        m_valid [SETS][WAYS];
    int          m_ptr   [SETS];

    always #10 Clk = ~Clk;

    icache_top i_dut (
        .Clk              (Clk),
        .arst_n           (arst_n),
        .read_enable      (read_enable),
        .read_address     (read_address),
        .mispredict       (mispredict),
        .mem_data         (mem_data),
        .mem_data_ready   (mem_data_ready),
        .instruction      (instruction),
        .ready            (ready),
        .busy             (busy),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request)
    );

    // Memory word is the address with halves swapped, then inverted
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return ~{addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v    = (v << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %s expected %h, got %h", name, expected, actual);
        end
    endtask

    // Hit test plus victim choice with the lowest free way before the pointer
    task automatic model_lookup(input logic [31:0] addr, output logic hit, output int way,
                                output logic from_ptr);
        int s;
        s        = int'(addr[SET_LSB +: $clog2(SETS)]);
        hit      = 1'b0;
        way      = m_ptr[s];
        from_ptr = 1'b1;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!m_valid[s][w]) begin
                way      = w;
                from_ptr = 1'b0;
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == (addr >> TAG_LSB)) begin
                hit = 1'b1;
            end
        end
    endtask

    task automatic model_commit(input logic [31:0] addr, input int way, input logic from_ptr);
        int s;
        s              = int'(addr[SET_LSB +: $clog2(SETS)]);
        m_valid[s][way] = 1'b1;
        m_tag[s][way]   = addr >> TAG_LSB;
        if (from_ptr) begin
            m_ptr[s] = (m_ptr[s] + 1) % WAYS;
        end
    endtask

    task automatic run_entry(input int idx);
        entry_t      e;
        logic        model_hit;
        logic        from_ptr;
        logic        aborted;
        int          way;
        int          cycles;
        int          errors_before;
        logic [31:0] block_addr;
        e             = STIM[idx];
        errors_before = errors;
        aborted       = 1'b0;
        block_addr    = e.addr & ~32'(WORDS * 4 - 1);
        model_lookup(e.addr, model_hit, way, from_ptr);
        check_value("model_hit", e.outcome == OUT_HIT, model_hit);

        @(negedge Clk);
        read_enable  = 1'b1;
        read_address = e.addr;
        @(negedge Clk);
        read_enable = e.hold;
        check_value("mem_read_request", e.outcome != OUT_HIT, mem_read_request);
        if (mem_read_request) begin
            check_value("mem_read_address", block_addr, mem_read_address);
            for (int i = 0; i < WORDS && !aborted; i++) begin
                if (e.abort_after == i) begin
                    // Strobe in the same cycle must lose to the mispredict
                    mispredict     = 1'b1;
                    mem_data_ready = 1'b1;
                    mem_data       = mem_word(block_addr + 32'(4 * i));
                    @(negedge Clk);
                    mispredict     = 1'b0;
                    mem_data_ready = 1'b0;
                    check_value("busy", 0, busy);
                    check_value("mem_read_request", 0, mem_read_request);
                    check_value("ready", 0, ready);
                    @(negedge Clk);
                    check_value("ready", 0, ready);
                    aborted = 1'b1;
                end else begin
                    // Memory latency before each word
                    repeat (take_bits(2)) @(negedge Clk);
                    check_value("busy", 1, busy);
                    check_value("mem_read_address", block_addr, mem_read_address);
                    mem_data_ready = 1'b1;
                    mem_data       = mem_word(block_addr + 32'(4 * i));
                    @(negedge Clk);
                    mem_data_ready = 1'b0;
                end
            end
        end
        read_enable = 1'b0;

        if (!aborted) begin
            cycles = 0;
            while (!ready && cycles < WAIT_LIMIT) begin
                @(negedge Clk);
                cycles++;
            end
            if (!ready) begin
                errors++;
                $display("entry %0d: no ready pulse within %0d cycles", idx, cycles);
            end else begin
                check_value("ready_latency", 0, cycles);
                check_value("instruction", mem_word(e.addr), instruction);
                check_value("busy", 0, busy);
                check_value("mem_read_request", 0, mem_read_request);
            end
            if (!model_hit) begin
                model_commit(e.addr, way, from_ptr);
            end
        end
        $display("entry %0d addr %h %s: %s", idx, e.addr,
                 (e.outcome == OUT_HIT) ? "hit" : (e.outcome == OUT_MISS) ? "miss" : "abort",
                 (errors == errors_before) ? "ok" : "mismatch");
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        arst_n         = 1'b0;
        read_enable    = 1'b0;
        read_address   = '0;
        mispredict     = 1'b0;
        mem_data       = '0;
        mem_data_ready = 1'b0;
        lfsr           = 32'h6486;
        errors         = 0;
        checks         = 0;
        for (int s = 0; s < SETS; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (8) @(negedge Clk);
        arst_n = 1'b1;
        check_value("ready", 0, ready);
        check_value("busy", 0, busy);
        check_value("mem_read_request", 0, mem_read_request);

        for (int i = 0; i < N_ENTRIES; i++) begin
            run_entry(i);
        end
        repeat (2) @(negedge Clk);
        errors += i_dut.i_checker.failures;
        $display("%0d entries, %0d checks, %0d errors", N_ENTRIES, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/icache_addr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module icache_addr_decode
    import icache_pkg::*;
#(
    parameter int NUM_SETS    = 4,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_BITS   = $clog2(NUM_SETS),
    localparam int WORD_BITS  = $clog2(BLOCK_WORDS),
    localparam int BLOCK_LSB  = BYTE_OFFSET_BITS + WORD_BITS,
    localparam int TAG_BITS   = ADDR_BITS - SET_BITS - BLOCK_LSB
) (
    input  logic                 Clk,
    input  logic                 arst_n,
    input  logic [ADDR_BITS-1:0] read_address,
    input  logic                 miss_start,
    output logic [SET_BITS-1:0]  lookup_set,
    output logic [TAG_BITS-1:0]  lookup_tag,
    output logic [WORD_BITS-1:0] lookup_word,
    output logic [SET_BITS-1:0]  refill_set,
    output logic [TAG_BITS-1:0]  refill_tag,
    output logic [WORD_BITS-1:0] refill_word,
    output logic [ADDR_BITS-1:0] mem_read_address
);

    logic [ADDR_BITS-1:0] miss_address;

    // Live fetch address fields
    assign lookup_word = read_address[BYTE_OFFSET_BITS +: WORD_BITS];
    assign lookup_set  = read_address[BLOCK_LSB +: SET_BITS];
    assign lookup_tag  = read_address[ADDR_BITS-1 -: TAG_BITS];

    // Miss address stays put for the whole refill
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            miss_address <= '0;
        end else if (miss_start) begin
            miss_address <= read_address;
        end
    end

    assign refill_word = miss_address[BYTE_OFFSET_BITS +: WORD_BITS];
    assign refill_set  = miss_address[BLOCK_LSB +: SET_BITS];
    assign refill_tag  = miss_address[ADDR_BITS-1 -: TAG_BITS];

    // Burst always starts at word 0 of the block
    assign mem_read_address = {miss_address[ADDR_BITS-1:BLOCK_LSB], {BLOCK_LSB{1'b0}}};

endmodule

`default_nettype wire

//--- verilog/icache_data_array.sv
`timescale 1ns/100ps
`default_nettype none

module icache_data_array
    import icache_pkg::*;
#(
    parameter int NUM_SETS    = 4,
    parameter int NUM_WAYS    = 2,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_BITS   = $clog2(NUM_SETS),
    localparam int WAY_BITS   = $clog2(NUM_WAYS),
    localparam int WORD_BITS  = $clog2(BLOCK_WORDS)
) (
    input  logic                  Clk,
    input  logic                  arst_n,
    input  logic                  lookup,
    input  logic [SET_BITS-1:0]   lookup_set,
    input  logic [WAY_BITS-1:0]   hit_way,
    input  logic [WORD_BITS-1:0]  lookup_word,
    input  logic                  word_strobe,
    input  logic [WORD_BITS-1:0]  fill_index,
    input  logic [INSTR_BITS-1:0] mem_data,
    input  logic                  fill_write,
    input  logic [SET_BITS-1:0]   refill_set,
    input  logic [WAY_BITS-1:0]   fill_way,
    input  logic [WORD_BITS-1:0]  refill_word,
    output logic [INSTR_BITS-1:0] instruction,
    output logic                  ready
);

    logic [INSTR_BITS-1:0] block_mem  [NUM_SETS][NUM_WAYS][BLOCK_WORDS];
    logic [INSTR_BITS-1:0] fill_buf   [BLOCK_WORDS];
    logic [INSTR_BITS-1:0] fill_block [BLOCK_WORDS];

    // Buffered words plus the one arriving this cycle
    always_comb begin
        fill_block             = fill_buf;
        fill_block[fill_index] = mem_data;
    end

    always_ff @(posedge Clk) begin
        if (word_strobe) begin
            fill_buf[fill_index] <= mem_data;
        end
        if (fill_write) begin
            block_mem[refill_set][fill_way] <= fill_block;
            instruction <= fill_block[refill_word];
        end else if (lookup) begin
            instruction <= block_mem[lookup_set][hit_way][lookup_word];
        end
    end

    // One-cycle pulse alongside each new instruction
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= lookup || fill_write;
        end
    end

endmodule

`default_nettype wire

//--- verilog/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // Fetch address and memory bus widths
    localparam int ADDR_BITS  = 32;
    localparam int INSTR_BITS = 32;

    // Byte select bits below one instruction word
    localparam int BYTE_OFFSET_BITS = 2;

    // Refill controller states
    typedef enum logic {
        FILL_IDLE,
        FILL_COLLECT
    } fill_state_t;

endpackage

`default_nettype wire

//--- verilog/icache_refill_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module icache_refill_ctrl
    import icache_pkg::*;
#(
    parameter int BLOCK_WORDS = 4,
    localparam int WORD_BITS  = $clog2(BLOCK_WORDS)
) (
    input  logic                 Clk,
    input  logic                 arst_n,
    input  logic                 read_enable,
    input  logic                 hit,
    input  logic                 mem_data_ready,
    input  logic                 mispredict,
    output logic                 busy,
    output logic                 mem_read_request,
    output logic                 lookup,
    output logic                 miss_start,
    output logic                 word_strobe,
    output logic [WORD_BITS-1:0] fill_index,
    output logic                 fill_write
);

    fill_state_t state;
    fill_state_t state_next;
    logic        accept;
    logic        last_word;

    // Fetches are only taken while no refill is running
    assign accept     = read_enable && (state == FILL_IDLE);
    assign lookup     = accept && hit;
    assign miss_start = accept && !hit;

    // Mispredict wins over a strobe in the same cycle
    assign word_strobe = (state == FILL_COLLECT) && mem_data_ready && !mispredict;
    assign last_word   = (fill_index == WORD_BITS'(BLOCK_WORDS - 1));
    assign fill_write  = word_strobe && last_word;

    assign busy             = (state == FILL_COLLECT);
    assign mem_read_request = (state == FILL_COLLECT);

    always_comb begin
        state_next = state;
        case (state)
            FILL_IDLE: begin
                if (miss_start) begin
                    state_next = FILL_COLLECT;
                end
            end
            FILL_COLLECT: begin
                // Abort or final word both end the burst
                if (mispredict || fill_write) begin
                    state_next = FILL_IDLE;
                end
            end
            default: begin
                state_next = FILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= FILL_IDLE;
            fill_index <= '0;
        end else begin
            state <= state_next;
            if (miss_start) begin
                fill_index <= '0;
            end else if (word_strobe) begin
                fill_index <= fill_index + WORD_BITS'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/icache_tag_array.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tag_array #(
    parameter int NUM_SETS   = 4,
    parameter int NUM_WAYS   = 2,
    parameter int TAG_BITS   = 26,
    localparam int SET_BITS  = $clog2(NUM_SETS),
    localparam int WAY_BITS  = $clog2(NUM_WAYS)
) (
    input  logic                Clk,
    input  logic                arst_n,
    input  logic [SET_BITS-1:0] lookup_set,
    input  logic [TAG_BITS-1:0] lookup_tag,
    input  logic [SET_BITS-1:0] refill_set,
    input  logic [TAG_BITS-1:0] refill_tag,
    input  logic                miss_start,
    input  logic                fill_write,
    output logic                hit,
    output logic [WAY_BITS-1:0] hit_way,
    output logic [WAY_BITS-1:0] fill_way
);

    logic [TAG_BITS-1:0] tag_mem [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid   [NUM_SETS];
    logic [WAY_BITS-1:0] rot_ptr [NUM_SETS];
    logic [WAY_BITS-1:0] victim_way;
    logic                victim_free;
    logic                victim_from_ptr;

    // Compare every way of the addressed set, lowest match wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (valid[lookup_set][w] && (tag_mem[lookup_set][w] == lookup_tag)) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    // Lowest invalid way first, else the set's rotation pointer
    always_comb begin
        victim_free = 1'b0;
        victim_way  = rot_ptr[lookup_set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid[lookup_set][w]) begin
                victim_free = 1'b1;
                victim_way  = WAY_BITS'(w);
            end
        end
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_way        <= '0;
            victim_from_ptr <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s]   <= '0;
                rot_ptr[s] <= '0;
            end
        end else begin
            if (miss_start) begin
                fill_way        <= victim_way;
                victim_from_ptr <= !victim_free;
            end
            if (fill_write) begin
                valid[refill_set][fill_way] <= 1'b1;
                // Pointer only moves when it actually picked the victim
                if (victim_from_ptr) begin
                    rot_ptr[refill_set] <= rot_ptr[refill_set] + WAY_BITS'(1);
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (fill_write) begin
            tag_mem[refill_set][fill_way] <= refill_tag;
        end
    end

endmodule

`default_nettype wire

//--- verilog/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top
    import icache_pkg::*;
#(
    parameter int NUM_SETS    = 4,
    parameter int NUM_WAYS    = 2,
    parameter int BLOCK_WORDS = 4,
    localparam int SET_BITS   = $clog2(NUM_SETS),
    localparam int WAY_BITS   = $clog2(NUM_WAYS),
    localparam int WORD_BITS  = $clog2(BLOCK_WORDS),
    localparam int TAG_BITS   = ADDR_BITS - SET_BITS - WORD_BITS - BYTE_OFFSET_BITS
) (
    input  logic                  Clk,
    input  logic                  arst_n,
    input  logic                  read_enable,
    input  logic [ADDR_BITS-1:0]  read_address,
    input  logic                  mispredict,
    input  logic [INSTR_BITS-1:0] mem_data,
    input  logic                  mem_data_ready,
    output logic [INSTR_BITS-1:0] instruction,
    output logic                  ready,
    output logic                  busy,
    output logic [ADDR_BITS-1:0]  mem_read_address,
    output logic                  mem_read_request
);

    logic [SET_BITS-1:0]  lookup_set;
    logic [TAG_BITS-1:0]  lookup_tag;
    logic [WORD_BITS-1:0] lookup_word;
    logic [SET_BITS-1:0]  refill_set;
    logic [TAG_BITS-1:0]  refill_tag;
    logic [WORD_BITS-1:0] refill_word;
    logic                 hit;
    logic [WAY_BITS-1:0]  hit_way;
    logic [WAY_BITS-1:0]  fill_way;
    logic                 lookup;
    logic                 miss_start;
    logic                 word_strobe;
    logic [WORD_BITS-1:0] fill_index;
    logic                 fill_write;

    icache_addr_decode #(
        .NUM_SETS    (NUM_SETS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_addr_decode (
        .Clk              (Clk),
        .arst_n           (arst_n),
        .read_address     (read_address),
        .miss_start       (miss_start),
        .lookup_set       (lookup_set),
        .lookup_tag       (lookup_tag),
        .lookup_word      (lookup_word),
        .refill_set       (refill_set),
        .refill_tag       (refill_tag),
        .refill_word      (refill_word),
        .mem_read_address (mem_read_address)
    );

    icache_tag_array #(
        .NUM_SETS (NUM_SETS),
        .NUM_WAYS (NUM_WAYS),
        .TAG_BITS (TAG_BITS)
    ) i_tag_array (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .lookup_set (lookup_set),
        .lookup_tag (lookup_tag),
        .refill_set (refill_set),
        .refill_tag (refill_tag),
        .miss_start (miss_start),
        .fill_write (fill_write),
        .hit        (hit),
        .hit_way    (hit_way),
        .fill_way   (fill_way)
    );

    icache_refill_ctrl #(
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_refill_ctrl (
        .Clk              (Clk),
        .arst_n           (arst_n),
        .read_enable      (read_enable),
        .hit              (hit),
        .mem_data_ready   (mem_data_ready),
        .mispredict       (mispredict),
        .busy             (busy),
        .mem_read_request (mem_read_request),
        .lookup           (lookup),
        .miss_start       (miss_start),
        .word_strobe      (word_strobe),
        .fill_index       (fill_index),
        .fill_write       (fill_write)
    );

    icache_data_array #(
        .NUM_SETS    (NUM_SETS),
        .NUM_WAYS    (NUM_WAYS),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) i_data_array (
        .Clk         (Clk),
        .arst_n      (arst_n),
        .lookup      (lookup),
        .lookup_set  (lookup_set),
        .hit_way     (hit_way),
        .lookup_word (lookup_word),
        .word_strobe (word_strobe),
        .fill_index  (fill_index),
        .mem_data    (mem_data),
        .fill_write  (fill_write),
        .refill_set  (refill_set),
        .fill_way    (fill_way),
        .refill_word (refill_word),
        .instruction (instruction),
        .ready       (ready)
    );

endmodule

`default_nettype wire
